/* hw/fspu_pkg.sv */
/*
  Shared types for the FSPU datapath of a 64-bit RISC-V core.
  All widths are fixed by the ISA (XLEN = FLEN = 64).
  Single and half values live NaN-boxed in the low bits of fpr_t.
*/
package fspu_pkg;

  localparam int XLEN     = 64;
  localparam int FLEN     = 64;
  localparam int PREG_W   = 7;
  localparam int FCLASS_W = 10;

  typedef logic [FLEN-1:0]     fpr_t;
  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [PREG_W-1:0]   preg_t;
  typedef logic [2:0]          fspu_op_t;
  typedef logic [1:0]          fspu_fmt_t;
  typedef logic [FCLASS_W-1:0] fclass_t;

  // Operation codes, 6 and 7 unused
  localparam fspu_op_t OP_FSGNJ   = 3'd0;
  localparam fspu_op_t OP_FSGNJN  = 3'd1;
  localparam fspu_op_t OP_FSGNJX  = 3'd2;
  localparam fspu_op_t OP_FMV_F_X = 3'd3;
  localparam fspu_op_t OP_FMV_X_F = 3'd4;
  localparam fspu_op_t OP_FCLASS  = 3'd5;

  localparam fspu_fmt_t FMT_D = 2'd0;
  localparam fspu_fmt_t FMT_S = 2'd1;
  localparam fspu_fmt_t FMT_H = 2'd2;

  // Substituted for badly boxed narrow operands
  localparam logic [31:0] CANON_NAN_S = 32'h7fc00000;
  localparam logic [15:0] CANON_NAN_H = 16'h7e00;

  typedef struct packed {
    fspu_op_t  op;
    fspu_fmt_t fmt;
    fpr_t      oper0;
    fpr_t      oper1;
    xlen_t     int_src;
    preg_t     dest;
  } fspu_issue_t;

  // One-hot, at most one set
  typedef struct packed {
    logic fmv_f_x;
    logic fsgnj;
    logic fsgnjn;
    logic fsgnjx;
  } fspu_sel_t;

  typedef struct packed {
    fspu_sel_t sel;
    logic      to_int;
    logic      is_fclass;
    fspu_fmt_t fmt;
    fpr_t      oper0;
    fpr_t      oper1;
    xlen_t     int_src;
    preg_t     dest;
  } fspu_ex1_t;

  typedef struct packed {
    fpr_t  fpr_result;
    xlen_t fclass_result;
    xlen_t fmv_x_result;
  } fspu_fmt_out_t;

  typedef struct packed {
    xlen_t data;
    preg_t dest;
    logic  to_int;
  } fspu_result_t;

endpackage

/* hw/fspu_double.sv */
/*
  Double-precision classify, sign injection and raw moves.
  Purely combinational. sel is one-hot; with no select the float result is zero.
*/
`timescale 1ns/1ps

module fspu_double (
  input  fspu_pkg::fspu_sel_t     sel,
  input  fspu_pkg::fpr_t          oper0,
  input  fspu_pkg::fpr_t          oper1,
  input  fspu_pkg::xlen_t         int_src,
  output fspu_pkg::fspu_fmt_out_t out
);
  import fspu_pkg::*;

  logic    sign0;
  logic    expo_max;
  logic    expo_zero;
  logic    frac_zero;
  logic    frac_msb;
  fclass_t cls;
  fpr_t    res_fsgnj;
  fpr_t    res_fsgnjn;
  fpr_t    res_fsgnjx;

  // Field decode of oper0
  assign sign0     = oper0[63];
  assign expo_max  = &oper0[62:52];
  assign expo_zero = ~|oper0[62:52];
  assign frac_zero = ~|oper0[51:0];
  assign frac_msb  = oper0[51];

  // FCLASS.D mask, bit 0 is -inf
  assign cls[0] =  sign0 &  expo_max  &  frac_zero;
  assign cls[1] =  sign0 & ~expo_max  & ~expo_zero;
  assign cls[2] =  sign0 &  expo_zero & ~frac_zero;
  assign cls[3] =  sign0 &  expo_zero &  frac_zero;
  assign cls[4] = ~sign0 &  expo_zero &  frac_zero;
  assign cls[5] = ~sign0 &  expo_zero & ~frac_zero;
  assign cls[6] = ~sign0 & ~expo_max  & ~expo_zero;
  assign cls[7] = ~sign0 &  expo_max  &  frac_zero;
  // NaNs ignore the sign
  assign cls[8] = expo_max & ~frac_zero & ~frac_msb;
  assign cls[9] = expo_max & frac_msb;

  // Sign injection keeps the magnitude of oper0
  assign res_fsgnj  = {oper1[63], oper0[62:0]};
  assign res_fsgnjn = {~oper1[63], oper0[62:0]};
  assign res_fsgnjx = {oper0[63] ^ oper1[63], oper0[62:0]};

  assign out.fpr_result = {FLEN{sel.fmv_f_x}} & int_src    |
                          {FLEN{sel.fsgnj}}   & res_fsgnj  |
                          {FLEN{sel.fsgnjn}}  & res_fsgnjn |
                          {FLEN{sel.fsgnjx}}  & res_fsgnjx;

  assign out.fclass_result = {{(XLEN-FCLASS_W){1'b0}}, cls};

  // FMV.X.D is a straight copy
  assign out.fmv_x_result = oper0;

endmodule

/* hw/fspu_single.sv */
/*
  Single-precision classify, sign injection and raw moves, NaN-boxing aware.
  Operands not boxed with ones in 63:32 read as the canonical NaN.
  Float results are boxed, FMV.X.W sign-extends without checking the box.
*/
`timescale 1ns/1ps

module fspu_single (
  input  fspu_pkg::fspu_sel_t     sel,
  input  fspu_pkg::fpr_t          oper0,
  input  fspu_pkg::fpr_t          oper1,
  input  fspu_pkg::xlen_t         int_src,
  output fspu_pkg::fspu_fmt_out_t out
);
  import fspu_pkg::*;

  logic        boxed0;
  logic        boxed1;
  logic [31:0] src0;
  logic [31:0] src1;
  logic        sign0;
  logic        expo_max;
  logic        expo_zero;
  logic        frac_zero;
  logic        frac_msb;
  fclass_t     cls;
  logic [31:0] res_fsgnj;
  logic [31:0] res_fsgnjn;
  logic [31:0] res_fsgnjx;
  fpr_t        box_fmv_f_x;
  fpr_t        box_fsgnj;
  fpr_t        box_fsgnjn;
  fpr_t        box_fsgnjx;

  // Unbox inputs
  assign boxed0 = &oper0[63:32];
  assign boxed1 = &oper1[63:32];
  assign src0   = boxed0 ? oper0[31:0] : CANON_NAN_S;
  assign src1   = boxed1 ? oper1[31:0] : CANON_NAN_S;

  assign sign0     = src0[31];
  assign expo_max  = &src0[30:23];
  assign expo_zero = ~|src0[30:23];
  assign frac_zero = ~|src0[22:0];
  assign frac_msb  = src0[22];

  // FCLASS.S
  assign cls[0] =  sign0 &  expo_max  &  frac_zero;
  assign cls[1] =  sign0 & ~expo_max  & ~expo_zero;
  assign cls[2] =  sign0 &  expo_zero & ~frac_zero;
  assign cls[3] =  sign0 &  expo_zero &  frac_zero;
  assign cls[4] = ~sign0 &  expo_zero &  frac_zero;
  assign cls[5] = ~sign0 &  expo_zero & ~frac_zero;
  assign cls[6] = ~sign0 & ~expo_max  & ~expo_zero;
  assign cls[7] = ~sign0 &  expo_max  &  frac_zero;
  assign cls[8] = expo_max & ~frac_zero & ~frac_msb;
  assign cls[9] = expo_max & frac_msb;

  assign res_fsgnj  = {src1[31], src0[30:0]};
  assign res_fsgnjn = {~src1[31], src0[30:0]};
  assign res_fsgnjx = {src0[31] ^ src1[31], src0[30:0]};

  // Box every candidate so an idle select still merges to zero
  assign box_fmv_f_x = {{32{1'b1}}, int_src[31:0]};
  assign box_fsgnj   = {{32{1'b1}}, res_fsgnj};
  assign box_fsgnjn  = {{32{1'b1}}, res_fsgnjn};
  assign box_fsgnjx  = {{32{1'b1}}, res_fsgnjx};

  assign out.fpr_result = {FLEN{sel.fmv_f_x}} & box_fmv_f_x |
                          {FLEN{sel.fsgnj}}   & box_fsgnj   |
                          {FLEN{sel.fsgnjn}}  & box_fsgnjn  |
                          {FLEN{sel.fsgnjx}}  & box_fsgnjx;

  assign out.fclass_result = {{(XLEN-FCLASS_W){1'b0}}, cls};

  // FMV.X.W uses raw low word of oper0
  assign out.fmv_x_result = {{32{oper0[31]}}, oper0[31:0]};

endmodule

/* hw/fspu_half.sv */
/*
  Half-precision classify, sign injection and raw moves, NaN-boxing aware.
  Operands not boxed with ones in 63:16 read as the canonical NaN.
  Float results are boxed, FMV.X.H sign-extends without checking the box.
*/
`timescale 1ns/1ps

module fspu_half (
  input  fspu_pkg::fspu_sel_t     sel,
  input  fspu_pkg::fpr_t          oper0,
  input  fspu_pkg::fpr_t          oper1,
  input  fspu_pkg::xlen_t         int_src,
  output fspu_pkg::fspu_fmt_out_t out
);
  import fspu_pkg::*;

  logic        boxed0;
  logic        boxed1;
  logic [15:0] src0;
  logic [15:0] src1;
  logic        sign0;
  logic        expo_max;
  logic        expo_zero;
  logic        frac_zero;
  logic        frac_msb;
  fclass_t     cls;
  logic [15:0] res_fsgnj;
  logic [15:0] res_fsgnjn;
  logic [15:0] res_fsgnjx;
  fpr_t        box_fmv_f_x;
  fpr_t        box_fsgnj;
  fpr_t        box_fsgnjn;
  fpr_t        box_fsgnjx;

  // Unbox inputs
  assign boxed0 = &oper0[63:16];
  assign boxed1 = &oper1[63:16];
  assign src0   = boxed0 ? oper0[15:0] : CANON_NAN_H;
  assign src1   = boxed1 ? oper1[15:0] : CANON_NAN_H;

  // 5-bit exponent, 10-bit fraction
  assign sign0     = src0[15];
  assign expo_max  = &src0[14:10];
  assign expo_zero = ~|src0[14:10];
  assign frac_zero = ~|src0[9:0];
  assign frac_msb  = src0[9];

  // FCLASS.H
  assign cls[0] =  sign0 &  expo_max  &  frac_zero;
  assign cls[1] =  sign0 & ~expo_max  & ~expo_zero;
  assign cls[2] =  sign0 &  expo_zero & ~frac_zero;
  assign cls[3] =  sign0 &  expo_zero &  frac_zero;
  assign cls[4] = ~sign0 &  expo_zero &  frac_zero;
  assign cls[5] = ~sign0 &  expo_zero & ~frac_zero;
  assign cls[6] = ~sign0 & ~expo_max  & ~expo_zero;
  assign cls[7] = ~sign0 &  expo_max  &  frac_zero;
  assign cls[8] = expo_max & ~frac_zero & ~frac_msb;
  assign cls[9] = expo_max & frac_msb;

  assign res_fsgnj  = {src1[15], src0[14:0]};
  assign res_fsgnjn = {~src1[15], src0[14:0]};
  assign res_fsgnjx = {src0[15] ^ src1[15], src0[14:0]};

  // Boxed candidates, merged AND-OR
  assign box_fmv_f_x = {{48{1'b1}}, int_src[15:0]};
  assign box_fsgnj   = {{48{1'b1}}, res_fsgnj};
  assign box_fsgnjn  = {{48{1'b1}}, res_fsgnjn};
  assign box_fsgnjx  = {{48{1'b1}}, res_fsgnjx};

  assign out.fpr_result = {FLEN{sel.fmv_f_x}} & box_fmv_f_x |
                          {FLEN{sel.fsgnj}}   & box_fsgnj   |
                          {FLEN{sel.fsgnjn}}  & box_fsgnjn  |
                          {FLEN{sel.fsgnjx}}  & box_fsgnjx;

  assign out.fclass_result = {{(XLEN-FCLASS_W){1'b0}}, cls};

  // FMV.X.H uses raw low half of oper0
  assign out.fmv_x_result = {{48{oper0[15]}}, oper0[15:0]};

endmodule

/* hw/fspu_issue.sv */
/*
  Issue register: one request per cycle, no stall.
  Unused op codes decode to no select and a zero float result.
*/
`timescale 1ns/1ps

module fspu_issue (
  input  logic                  forever_cpuclk,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  fspu_pkg::fspu_issue_t issue,
  output logic                  ex1_valid,
  output fspu_pkg::fspu_ex1_t   ex1
);
  import fspu_pkg::*;

  fspu_ex1_t ex1_nxt;

  // Op code to one-hot selects
  always_comb begin
    ex1_nxt             = '0;
    ex1_nxt.sel.fsgnj   = (issue.op == OP_FSGNJ);
    ex1_nxt.sel.fsgnjn  = (issue.op == OP_FSGNJN);
    ex1_nxt.sel.fsgnjx  = (issue.op == OP_FSGNJX);
    ex1_nxt.sel.fmv_f_x = (issue.op == OP_FMV_F_X);
    ex1_nxt.to_int      = (issue.op == OP_FMV_X_F) || (issue.op == OP_FCLASS);
    ex1_nxt.is_fclass   = (issue.op == OP_FCLASS);
    ex1_nxt.fmt         = issue.fmt;
    ex1_nxt.oper0       = issue.oper0;
    ex1_nxt.oper1       = issue.oper1;
    ex1_nxt.int_src     = issue.int_src;
    ex1_nxt.dest        = issue.dest;
  end

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ex1_valid <= 1'b0;
    end else begin
      ex1_valid <= issue_valid;
    end
  end

  // Payload only loads on a valid request
  always_ff @(posedge forever_cpuclk) begin
    if (issue_valid) begin
      ex1 <= ex1_nxt;
    end
  end

endmodule

/* hw/fspu_wb.sv */
/*
  Write-back stage: format and destination select, one register stage.
  No back-pressure, the consumer takes each result the cycle it shows.
*/
`timescale 1ns/1ps

module fspu_wb (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  input  logic                    ex1_valid,
  input  fspu_pkg::fspu_ex1_t     ex1,
  input  fspu_pkg::fspu_fmt_out_t out_d,
  input  fspu_pkg::fspu_fmt_out_t out_s,
  input  fspu_pkg::fspu_fmt_out_t out_h,
  output logic                    result_valid,
  output fspu_pkg::fspu_result_t  result
);
  import fspu_pkg::*;

  fspu_fmt_out_t fmt_out;
  fspu_result_t  result_nxt;

  // Format mux, reserved encoding gives zero
  always_comb begin
    case (ex1.fmt)
      FMT_D:   fmt_out = out_d;
      FMT_S:   fmt_out = out_s;
      FMT_H:   fmt_out = out_h;
      default: fmt_out = '0;
    endcase
  end

  always_comb begin
    if (ex1.is_fclass) begin
      result_nxt.data = fmt_out.fclass_result;
    end else if (ex1.to_int) begin
      result_nxt.data = fmt_out.fmv_x_result;
    end else begin
      result_nxt.data = fmt_out.fpr_result;
    end
    result_nxt.dest   = ex1.dest;
    result_nxt.to_int = ex1.to_int;
  end

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= ex1_valid;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (ex1_valid) begin
      result <= result_nxt;
    end
  end

endmodule

/* hw/fspu_top.sv */
/*
  FSPU top: issue, three format blocks, write-back.
  Two-cycle latency, results return in issue order.
*/
`timescale 1ns/1ps

module fspu_top (
  input  logic                   forever_cpuclk,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  fspu_pkg::fspu_issue_t  issue,
  output logic                   result_valid,
  output fspu_pkg::fspu_result_t result
);
  import fspu_pkg::*;

  logic          ex1_valid;
  fspu_ex1_t     ex1;
  fspu_fmt_out_t out_d;
  fspu_fmt_out_t out_s;
  fspu_fmt_out_t out_h;

  fspu_issue u_issue (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .ex1_valid      (ex1_valid),
    .ex1            (ex1)
  );

  // All formats compute in parallel, write-back picks one
  fspu_double u_double (
    .sel     (ex1.sel),
    .oper0   (ex1.oper0),
    .oper1   (ex1.oper1),
    .int_src (ex1.int_src),
    .out     (out_d)
  );

  fspu_single u_single (
    .sel     (ex1.sel),
    .oper0   (ex1.oper0),
    .oper1   (ex1.oper1),
    .int_src (ex1.int_src),
    .out     (out_s)
  );

  fspu_half u_half (
    .sel     (ex1.sel),
    .oper0   (ex1.oper0),
    .oper1   (ex1.oper1),
    .int_src (ex1.int_src),
    .out     (out_h)
  );

  fspu_wb u_wb (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .ex1_valid      (ex1_valid),
    .ex1            (ex1),
    .out_d          (out_d),
    .out_s          (out_s),
    .out_h          (out_h),
    .result_valid   (result_valid),
    .result         (result)
  );

endmodule

/* testbench/tb_clock.sv */
/*
  Free-running clock with an 8 ns period.
  Reset is held high for the first 16 rising edges and then released on an edge.
*/
`timescale 1ns/1ps

module tb_clock (
  output logic forever_cpuclk,
  output logic reset
);

  initial begin
    forever_cpuclk = 1'b0;
    forever #4 forever_cpuclk = ~forever_cpuclk;
  end

  initial begin
    reset <= 1'b1;
    repeat (16) @(posedge forever_cpuclk);
    reset <= 1'b0;
  end

endmodule

/* testbench/tb_fspu.sv */
/*
  Self-checking testbench for fspu_top.
  Expected results come from a model of the RISC-V sign injection, FCLASS and FMV rules.
  The consumer never stalls, so every result is checked the cycle it appears.
*/
`timescale 1ns/1ps

module tb_fspu;
  import fspu_pkg::*;

  localparam int N_DIRECTED = 51;
  localparam int N_RANDOM   = 2000;

  logic         forever_cpuclk;
  logic         reset;
  logic         issue_valid;
  fspu_issue_t  issue;
  logic         result_valid;
  fspu_result_t result;

  fspu_result_t exp_q[$];
  int           issue_cyc_q[$];
  int           cycle;
  int           n_checked;
  logic [31:0]  rng_state = 32'h31b4;

  tb_clock u_clock (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset)
  );

  fspu_top DUT (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .result_valid   (result_valid),
    .result         (result)
  );

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int width_of(input fspu_fmt_t fmt);
    return (fmt == FMT_D) ? 64 : (fmt == FMT_S) ? 32 : 16;
  endfunction

  function automatic int expo_width(input int w);
    return (w == 64) ? 11 : (w == 32) ? 8 : 5;
  endfunction

  function automatic xlen_t low_mask(input int w);
    return (w >= 64) ? {64{1'b1}} : (64'd1 << w) - 64'd1;
  endfunction

  // Fill the bits above the value with ones
  function automatic fpr_t box_value(input fspu_fmt_t fmt, input fpr_t raw);
    return raw | ~low_mask(width_of(fmt));
  endfunction

  // Narrow operands without a full box read as the canonical NaN
  function automatic xlen_t unbox(input fpr_t v, input int w);
    xlen_t m;
    m = low_mask(w);
    if (w == 64 || (v | m) == {64{1'b1}}) begin
      return v & m;
    end
    return (w == 32) ? 64'(CANON_NAN_S) : 64'(CANON_NAN_H);
  endfunction

  // One encoding for each mask bit from 0 to 9
  function automatic fpr_t make_special(input fspu_fmt_t fmt, input int idx);
    int    w;
    int    f_w;
    xlen_t expo;
    xlen_t frac;
    w    = width_of(fmt);
    f_w  = w - 1 - expo_width(w);
    expo = low_mask(expo_width(w));
    frac = 64'd0;
    case (idx)
      1, 6: begin
        expo = 64'd3;
        frac = 64'h2a;
      end
      2, 5: begin
        expo = 64'd0;
        frac = 64'h5;
      end
      3, 4:    expo = 64'd0;
      8:       frac = 64'd1;
      9:       frac = 64'd1 << (f_w - 1);
      default: frac = 64'd0;
    endcase
    return box_value(fmt, (64'(idx <= 3) << (w - 1)) | (expo << f_w) | frac);
  endfunction

  function automatic fclass_t classify(input xlen_t a, input int w);
    int    e_w;
    int    f_w;
    int    idx;
    logic  neg;
    xlen_t expo;
    xlen_t frac;
    e_w  = expo_width(w);
    f_w  = w - 1 - e_w;
    neg  = a[w-1];
    expo = (a >> f_w) & low_mask(e_w);
    frac = a & low_mask(f_w);
    if (expo == low_mask(e_w)) begin
      idx = (frac == 64'd0) ? (neg ? 0 : 7) : (a[f_w-1] ? 9 : 8);
    end else if (expo == 64'd0) begin
      idx = (frac == 64'd0) ? (neg ? 3 : 4) : (neg ? 2 : 5);
    end else begin
      idx = neg ? 1 : 6;
    end
    return fclass_t'(1) << idx;
  endfunction

  function automatic fspu_result_t fspu_model(input fspu_issue_t req);
    fspu_result_t r;
    int           w;
    xlen_t        m;
    xlen_t        s;
    xlen_t        a;
    xlen_t        b;
    w        = width_of(req.fmt);
    m        = low_mask(w);
    s        = 64'd1 << (w - 1);
    a        = unbox(req.oper0, w);
    b        = unbox(req.oper1, w);
    r.dest   = req.dest;
    r.to_int = (req.op == OP_FMV_X_F) || (req.op == OP_FCLASS);
    case (req.op)
      OP_FSGNJ:   r.data = ~m | (a & ~s) | (b & s);
      OP_FSGNJN:  r.data = ~m | (a & ~s) | (~b & s);
      OP_FSGNJX:  r.data = ~m | (a & ~s) | ((a ^ b) & s);
      OP_FMV_F_X: r.data = ~m | (req.int_src & m);
      OP_FMV_X_F: r.data = (req.oper0 & m) | (req.oper0[w-1] ? ~m : 64'd0);
      OP_FCLASS:  r.data = 64'(classify(a, w));
      default:    r.data = 64'd0;
    endcase
    return r;
  endfunction

  // Random operand with occasional specials and broken boxes
  function automatic fpr_t rand_operand(input fspu_fmt_t fmt);
    logic [31:0] pick;
    fpr_t        raw;
    pick = xorshift32();
    raw  = {xorshift32(), xorshift32()};
    if (pick[2:0] == 3'd0) begin
      raw = make_special(fmt, int'(pick[31:28]) % 10);
    end else if (pick[6:3] != 4'd0) begin
      raw = box_value(fmt, raw);
    end
    return raw;
  endfunction

  function automatic fspu_issue_t make_req(input fspu_op_t op, input fspu_fmt_t fmt,
                                           input fpr_t oper0, input fpr_t oper1);
    fspu_issue_t req;
    req.op      = op;
    req.fmt     = fmt;
    req.oper0   = oper0;
    req.oper1   = oper1;
    req.int_src = {xorshift32(), xorshift32()};
    req.dest    = preg_t'(xorshift32());
    return req;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_result(input fspu_result_t got, input fspu_result_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail at %0t: data %h dest %0d to_int %b, expected %h %0d %b",
                              $time, got.data, got.dest, got.to_int,
                              exp.data, exp.dest, exp.to_int));
    end
  endtask

  task automatic check_latency(input int got_cycle, input int issue_cycle);
    if (got_cycle != issue_cycle + 2) begin
      stop_on_error($sformatf("Fail at %0t: result in cycle %0d for issue in cycle %0d",
                              $time, got_cycle, issue_cycle));
    end
  endtask

  // Drives at a rising edge and returns at the edge that accepts the request
  task automatic send(input fspu_issue_t req);
    issue_valid <= 1'b1;
    issue       <= req;
    @(posedge forever_cpuclk);
  endtask

  task automatic idle();
    issue_valid <= 1'b0;
    @(posedge forever_cpuclk);
  endtask

  task automatic send_random();
    logic [31:0] pick;
    fspu_fmt_t   fmt;
    pick = xorshift32();
    fmt  = fspu_fmt_t'((pick >> 8) % 3);
    send(make_req(fspu_op_t'(pick % 6), fmt, rand_operand(fmt), rand_operand(fmt)));
    if (pick[31:30] == 2'b00) begin
      idle();
    end
  endtask

  // Record accepted requests and compare each result with the oldest
  always @(posedge forever_cpuclk) begin
    cycle <= cycle + 1;
    if (reset === 1'b0) begin
      if (issue_valid === 1'b1) begin
        exp_q.push_back(fspu_model(issue));
        issue_cyc_q.push_back(cycle);
      end
      if (result_valid !== 1'b0) begin
        if (result_valid !== 1'b1) begin
          stop_on_error("result_valid is unknown after reset");
        end else if (exp_q.size() == 0) begin
          stop_on_error("result_valid went high with no request outstanding");
        end else begin
          check_result(result, exp_q.pop_front());
          check_latency(cycle, issue_cyc_q.pop_front());
          n_checked++;
        end
      end
    end
  end

  initial begin
    fspu_fmt_t fmt;
    fpr_t      raw;
    int        wait_cycles;
    issue_valid <= 1'b0;
    issue       <= '0;
    while (reset !== 1'b0) begin
      @(posedge forever_cpuclk);
    end
    repeat (3) idle();

    // FCLASS on every class in every format
    for (int f = 0; f < 3; f++) begin
      for (int k = 0; k < 10; k++) begin
        send(make_req(OP_FCLASS, fspu_fmt_t'(f), make_special(fspu_fmt_t'(f), k), '0));
      end
    end

    for (int f = 0; f < 3; f++) begin
      fmt = fspu_fmt_t'(f);
      for (int o = 0; o < 3; o++) begin
        send(make_req(fspu_op_t'(o), fmt,
                      box_value(fmt, {xorshift32(), xorshift32()}),
                      box_value(fmt, {xorshift32(), xorshift32()})));
      end
    end

    // Bit 62 cleared breaks the box of single and half operands
    for (int f = 1; f < 3; f++) begin
      fmt = fspu_fmt_t'(f);
      raw = {xorshift32(), xorshift32()} & ~(64'd1 << 62);
      send(make_req(OP_FCLASS, fmt, raw, '0));
      send(make_req(OP_FSGNJ, fmt, raw, box_value(fmt, {xorshift32(), xorshift32()})));
      send(make_req(OP_FSGNJX, fmt, box_value(fmt, {xorshift32(), xorshift32()}), raw));
    end

    // Negative values for the integer moves
    for (int f = 0; f < 3; f++) begin
      fmt = fspu_fmt_t'(f);
      raw = {xorshift32(), xorshift32()} | (64'd1 << (width_of(fmt) - 1));
      send(make_req(OP_FMV_X_F, fmt, raw, '0));
      send(make_req(OP_FMV_F_X, fmt, '0, '0));
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      send_random();
    end
    idle();

    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 8) begin
      @(posedge forever_cpuclk);
      wait_cycles++;
    end
    repeat (4) @(posedge forever_cpuclk);

    if (exp_q.size() != 0) begin
      stop_on_error($sformatf("%0d expected results never arrived", exp_q.size()));
    end else begin
      $display("%0d results checked", n_checked);
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  initial begin
    #((N_DIRECTED + N_RANDOM) * 4 * 8 + 1000);
    stop_on_error("Watchdog timeout: the run did not finish in time");
  end

endmodule

/* tb.f */
hw/fspu_pkg.sv
hw/fspu_double.sv
hw/fspu_single.sv
hw/fspu_half.sv
hw/fspu_issue.sv
hw/fspu_wb.sv
hw/fspu_top.sv
testbench/tb_clock.sv
testbench/tb_fspu.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv testbench/*.sv)

all: run

obj_dir/Vtb_fspu: tb.f $(SRCS)
	verilator --binary --timing --top-module tb_fspu -f tb.f

run: obj_dir/Vtb_fspu
	@out="$$(./obj_dir/Vtb_fspu)"; echo "$$out"; \
	  echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: all run clean
